/* div_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_consts.svh"

module div_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  muldiv_pkg::muldiv_req_t req,
    output logic                    done,
    output muldiv_pkg::muldiv_rsp_t rsp,
    output logic                    div_by_zero
);

    localparam int CNT_W = $clog2(`MULDIV_XLEN);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(`MULDIV_XLEN - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FIX,
        ST_FINISH
    } state_t;

    state_t               state;
    logic [CNT_W-1:0]     iter_cnt;
    logic                 neg_q;
    logic                 neg_r;
    logic                 dbz;

    muldiv_pkg::word_t    quo;        // Dividend bits shift out as quotient bits shift in
    muldiv_pkg::word_t    rem;
    muldiv_pkg::word_t    dsr;        // Divisor magnitude

    logic                 neg_a;
    logic                 neg_b;
    muldiv_pkg::word_t    mag_a;
    muldiv_pkg::word_t    mag_b;
    logic [`MULDIV_XLEN:0] trial;
    logic                 trial_neg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand magnitudes and one restoring step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign neg_a = req.is_signed & req.src_a[`MULDIV_XLEN-1];
    assign neg_b = req.is_signed & req.src_b[`MULDIV_XLEN-1];
    assign mag_a = neg_a ? -req.src_a : req.src_a;
    assign mag_b = neg_b ? -req.src_b : req.src_b;

    assign trial     = {rem, quo[`MULDIV_XLEN-1]} - {1'b0, dsr};
    assign trial_neg = trial[`MULDIV_XLEN];  // Borrow means the divisor did not fit

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            iter_cnt <= '0;
            neg_q    <= 1'b0;
            neg_r    <= 1'b0;
            dbz      <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        iter_cnt <= '0;
                        neg_q    <= neg_a ^ neg_b;
                        neg_r    <= neg_a;
                        dbz      <= (req.src_b == '0);
                        // A zero divisor bypasses the iterations entirely
                        state    <= (req.src_b == '0) ? ST_FIX : ST_RUN;
                    end
                end
                ST_RUN: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == LAST_ITER) begin
                        state <= ST_FIX;
                    end
                end
                ST_FIX:    state <= ST_FINISH;
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Quotient and remainder datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            dsr <= mag_b;
            if (req.src_b == '0) begin
                quo <= '1;            // Fixed result for a zero divisor
                rem <= req.src_a;     // HI returns the raw dividend
            end else begin
                quo <= mag_a;
                rem <= '0;
            end
        end else if (state == ST_RUN) begin
            quo <= {quo[`MULDIV_XLEN-2:0], ~trial_neg};
            rem <= trial_neg ? {rem[`MULDIV_XLEN-2:0], quo[`MULDIV_XLEN-1]}
                             : trial[`MULDIV_XLEN-1:0];
        end else if (state == ST_FIX && !dbz) begin
            // Quotient truncates toward zero, remainder follows the dividend
            if (neg_q) begin
                quo <= -quo;
            end
            if (neg_r) begin
                rem <= -rem;
            end
        end
    end

    assign done        = (state == ST_FINISH);
    assign rsp.hi      = rem;
    assign rsp.lo      = quo;
    assign div_by_zero = dbz;

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == ST_IDLE)
        else $error("div_unit received start while an operation was running");

endmodule

`default_nettype wire

/* muldiv_consts.svh */
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MULDIV_XLEN        32
`define MULDIV_SLICES      4
`define MULDIV_SLICE_W     (`MULDIV_XLEN / `MULDIV_SLICES)  // Multiplier bits per cycle
`define MULDIV_AWIDTH      8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MULDIV_ADDR_SRC_A  8'h00
`define MULDIV_ADDR_SRC_B  8'h04
`define MULDIV_ADDR_CTRL   8'h08                           // Writing here starts a command
`define MULDIV_ADDR_STATUS 8'h0C
`define MULDIV_ADDR_HI     8'h10
`define MULDIV_ADDR_LO     8'h14

// CTRL and STATUS bit positions
`define MULDIV_CTRL_SIGNED   0
`define MULDIV_CTRL_DIV      1
`define MULDIV_STATUS_BUSY   0
`define MULDIV_STATUS_DONE   1
`define MULDIV_STATUS_DBZ    2

`endif

/* muldiv_pkg.sv */
`default_nettype none

`include "muldiv_consts.svh"

package muldiv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scalar types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`MULDIV_XLEN-1:0]   word_t;      // One operand or result word
    typedef logic [2*`MULDIV_XLEN-1:0] dword_t;     // Full width product
    typedef logic [`MULDIV_AWIDTH-1:0] apb_addr_t;  // Register offset on APB

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles between the register block and the arithmetic units
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Operands of one operation, held stable until done
    typedef struct packed {
        word_t src_a;      // Dividend or multiplier
        word_t src_b;      // Divisor or multiplicand
        logic  is_signed;
    } muldiv_req_t;

    // Result as the host sees it in HI and LO
    typedef struct packed {
        word_t hi;         // Upper product half or remainder
        word_t lo;         // Lower product half or quotient
    } muldiv_rsp_t;

endpackage

`default_nettype wire

/* muldiv_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_consts.svh"

module muldiv_regs (
    input  logic                    clk,
    input  logic                    rst_n,

    // APB slave
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  muldiv_pkg::apb_addr_t   paddr,
    input  muldiv_pkg::word_t       pwdata,
    output muldiv_pkg::word_t       prdata,
    output logic                    pready,
    output logic                    pslverr,

    // Arithmetic units
    output muldiv_pkg::muldiv_req_t req,
    output logic                    mult_start,
    output logic                    div_start,
    input  logic                    mult_done,
    input  logic                    div_done,
    input  muldiv_pkg::muldiv_rsp_t mult_rsp,
    input  muldiv_pkg::muldiv_rsp_t div_rsp,
    input  logic                    div_by_zero
);

    muldiv_pkg::word_t       src_a;
    muldiv_pkg::word_t       src_b;
    muldiv_pkg::word_t       hi;
    muldiv_pkg::word_t       lo;
    logic                    ctrl_signed;
    logic                    ctrl_div;
    logic                    busy;
    logic                    st_done;
    logic                    st_dbz;

    logic                    access;
    logic                    wr_en;
    logic                    ctrl_wr;
    logic                    ctrl_accept;
    logic                    unit_done;
    muldiv_pkg::muldiv_rsp_t done_rsp;
    muldiv_pkg::word_t       ctrl_word;
    muldiv_pkg::word_t       status_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access      = psel & penable;  // No wait states so every access phase completes
    assign wr_en       = access & pwrite;
    assign ctrl_wr     = wr_en & (paddr == `MULDIV_ADDR_CTRL);
    assign ctrl_accept = ctrl_wr & ~busy;

    assign pready  = 1'b1;
    assign pslverr = ctrl_wr & busy;      // Command refused while one is in flight

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_en && paddr == `MULDIV_ADDR_SRC_A) begin
            src_a <= pwdata;
        end
        if (wr_en && paddr == `MULDIV_ADDR_SRC_B) begin
            src_b <= pwdata;
        end
        // The units see a frozen copy so the host may reload operands early
        if (ctrl_accept) begin
            req.src_a     <= src_a;
            req.src_b     <= src_b;
            req.is_signed <= pwdata[`MULDIV_CTRL_SIGNED];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command, status and result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign unit_done = mult_done | div_done;
    assign done_rsp  = div_done ? div_rsp : mult_rsp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_signed <= 1'b0;
            ctrl_div    <= 1'b0;
            busy        <= 1'b0;
            st_done     <= 1'b0;
            st_dbz      <= 1'b0;
            mult_start  <= 1'b0;
            div_start   <= 1'b0;
            hi          <= '0;
            lo          <= '0;
        end else begin
            mult_start <= 1'b0;
            div_start  <= 1'b0;
            if (ctrl_accept) begin
                ctrl_signed <= pwdata[`MULDIV_CTRL_SIGNED];
                ctrl_div    <= pwdata[`MULDIV_CTRL_DIV];
                busy        <= 1'b1;
                st_done     <= 1'b0;
                st_dbz      <= 1'b0;
                mult_start  <= ~pwdata[`MULDIV_CTRL_DIV];
                div_start   <= pwdata[`MULDIV_CTRL_DIV];
            end
            if (unit_done) begin
                busy    <= 1'b0;
                st_done <= 1'b1;
                st_dbz  <= div_done & div_by_zero;
                hi      <= done_rsp.hi;
                lo      <= done_rsp.lo;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ctrl_word                         = '0;
        ctrl_word[`MULDIV_CTRL_SIGNED]    = ctrl_signed;
        ctrl_word[`MULDIV_CTRL_DIV]       = ctrl_div;
        status_word                       = '0;
        status_word[`MULDIV_STATUS_BUSY]  = busy;
        status_word[`MULDIV_STATUS_DONE]  = st_done;
        status_word[`MULDIV_STATUS_DBZ]   = st_dbz;
    end

    always_comb begin
        case (paddr)
            `MULDIV_ADDR_SRC_A:  prdata = src_a;
            `MULDIV_ADDR_SRC_B:  prdata = src_b;
            `MULDIV_ADDR_CTRL:   prdata = ctrl_word;
            `MULDIV_ADDR_STATUS: prdata = status_word;
            `MULDIV_ADDR_HI:     prdata = hi;
            `MULDIV_ADDR_LO:     prdata = lo;
            default:             prdata = '0;
        endcase
    end

    a_done_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (mult_done || div_done) |-> busy)
        else $error("Arithmetic unit reported done with no command in flight");

endmodule

`default_nettype wire

/* muldiv_top.f */
+incdir+.
muldiv_pkg.sv
mult_unit.sv
div_unit.sv
muldiv_regs.sv
muldiv_top.sv
tb_muldiv_top.sv

/* muldiv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module muldiv_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  muldiv_pkg::apb_addr_t paddr,
    input  muldiv_pkg::word_t     pwdata,
    output muldiv_pkg::word_t     prdata,
    output logic                  pready,
    output logic                  pslverr
);

    muldiv_pkg::muldiv_req_t req;
    muldiv_pkg::muldiv_rsp_t mult_rsp;
    muldiv_pkg::muldiv_rsp_t div_rsp;
    logic                    mult_start;
    logic                    div_start;
    logic                    mult_done;
    logic                    div_done;
    logic                    div_by_zero;

    // Register block steers both units through one shared request
    muldiv_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .req         (req),
        .mult_start  (mult_start),
        .div_start   (div_start),
        .mult_done   (mult_done),
        .div_done    (div_done),
        .mult_rsp    (mult_rsp),
        .div_rsp     (div_rsp),
        .div_by_zero (div_by_zero)
    );

    mult_unit u_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mult_start),
        .req   (req),
        .done  (mult_done),
        .rsp   (mult_rsp)
    );

    div_unit u_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (div_start),
        .req         (req),
        .done        (div_done),
        .rsp         (div_rsp),
        .div_by_zero (div_by_zero)
    );

endmodule

`default_nettype wire

/* mult_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_consts.svh"

module mult_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  muldiv_pkg::muldiv_req_t req,
    output logic                    done,
    output muldiv_pkg::muldiv_rsp_t rsp
);

    localparam int SLICE_W = `MULDIV_SLICE_W;
    localparam int CNT_W   = $clog2(`MULDIV_SLICES + 1);
    localparam logic [CNT_W-1:0] LAST_SLICE = CNT_W'(`MULDIV_SLICES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FINISH
    } state_t;

    state_t               state;
    logic [CNT_W-1:0]     slice_cnt;
    logic                 negate;

    muldiv_pkg::word_t    mp;         // Remaining multiplier magnitude
    muldiv_pkg::dword_t   mc;         // Multiplicand aligned to the current slice
    muldiv_pkg::dword_t   sum;

    logic                 neg_a;
    logic                 neg_b;
    muldiv_pkg::word_t    mag_a;
    muldiv_pkg::word_t    mag_b;
    muldiv_pkg::dword_t   slice_ext;
    muldiv_pkg::dword_t   partial;
    muldiv_pkg::dword_t   product;
    logic                 run_stop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand magnitudes and the per-slice partial product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign neg_a = req.is_signed & req.src_a[`MULDIV_XLEN-1];
    assign neg_b = req.is_signed & req.src_b[`MULDIV_XLEN-1];
    assign mag_a = neg_a ? -req.src_a : req.src_a;  // SRC_A drives the slices
    assign mag_b = neg_b ? -req.src_b : req.src_b;

    assign slice_ext = {{(2*`MULDIV_XLEN-SLICE_W){1'b0}}, mp[SLICE_W-1:0]};
    assign partial   = slice_ext * mc;

    // Nothing left to add once the multiplier has run out of set bits
    assign run_stop = (mp == '0) || (slice_cnt == LAST_SLICE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            slice_cnt <= '0;
            negate    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_RUN;
                        slice_cnt <= '0;
                        negate    <= neg_a ^ neg_b;
                    end
                end
                ST_RUN: begin
                    if (run_stop) begin
                        state <= ST_FINISH;
                    end else begin
                        slice_cnt <= slice_cnt + 1'b1;
                    end
                end
                ST_FINISH: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift and accumulate datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            mp  <= mag_a;
            mc  <= {{`MULDIV_XLEN{1'b0}}, mag_b};
            sum <= '0;
        end else if (state == ST_RUN && !run_stop) begin
            sum <= sum + partial;
            mp  <= mp >> SLICE_W;
            mc  <= mc << SLICE_W;
        end
    end

    assign product = negate ? -sum : sum;  // Sign applied only at the end
    assign done    = (state == ST_FINISH);
    assign rsp.hi  = product[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
    assign rsp.lo  = product[`MULDIV_XLEN-1:0];

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == ST_IDLE)
        else $error("mult_unit received start while an operation was running");

endmodule

`default_nettype wire

/* tb_muldiv_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_consts.svh"

module tb_muldiv_top;

    localparam int MAX_POLLS = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    muldiv_pkg::apb_addr_t paddr;
    muldiv_pkg::word_t     pwdata;
    muldiv_pkg::word_t     prdata;
    logic                  pready;
    logic                  pslverr;

    int                    value_errors;
    int                    timeouts;
    int                    timing_errors;
    muldiv_pkg::word_t     lcg_state;

    muldiv_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol and latency checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (u_dut.div_start && u_dut.req.src_b != '0) |-> ##34 u_dut.div_done)
        else begin
            timing_errors++;
            $display("Divider done did not come 34 cycles after its start");
        end

    a_div_zero_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (u_dut.div_start && u_dut.req.src_b == '0) |-> ##2 u_dut.div_done)
        else begin
            timing_errors++;
            $display("Divide by zero did not finish 2 cycles after its start");
        end

    a_mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
        u_dut.mult_start |-> ##[2:(`MULDIV_SLICES+2)] u_dut.mult_done)
        else begin
            timing_errors++;
            $display("Multiplier done did not come within the allowed window");
        end

    a_no_wait_states: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            timing_errors++;
            $display("APB pready dropped low");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic muldiv_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic muldiv_pkg::muldiv_rsp_t expected_result(
        input muldiv_pkg::word_t a,
        input muldiv_pkg::word_t b,
        input logic              is_signed,
        input logic              is_div
    );
        muldiv_pkg::muldiv_rsp_t r;
        muldiv_pkg::dword_t      prod;
        if (!is_div) begin
            if (is_signed) begin
                prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            end else begin
                prod = {32'd0, a} * {32'd0, b};
            end
            r.hi = prod[63:32];
            r.lo = prod[31:0];
        end else if (b == '0) begin
            r.lo = '1;
            r.hi = a;
        end else if (is_signed && a == 32'h8000_0000 && b == '1) begin
            r.lo = a;                         // Overflow case wraps to the minimum
            r.hi = '0;
        end else if (is_signed) begin
            r.lo = $signed(a) / $signed(b);
            r.hi = $signed(a) % $signed(b);
        end else begin
            r.lo = a / b;
            r.hi = a % b;
        end
        return r;
    endfunction

    task automatic apb_write(input muldiv_pkg::apb_addr_t addr, input muldiv_pkg::word_t data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;                        // Middle of the access phase
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input muldiv_pkg::apb_addr_t addr, output muldiv_pkg::word_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_word(input string name, input muldiv_pkg::word_t exp,
                              input muldiv_pkg::word_t act);
        assert (act === exp)
            else begin
                value_errors++;
                $display("ERROR %s expected %h actual %h", name, exp, act);
            end
    endtask

    task automatic wait_idle(input string name);
        muldiv_pkg::word_t status;
        int                polls;
        polls = 0;
        do begin
            apb_read(`MULDIV_ADDR_STATUS, status);
            polls++;
        end while (status[`MULDIV_STATUS_BUSY] && polls < MAX_POLLS);
        if (status[`MULDIV_STATUS_BUSY]) begin
            timeouts++;
            $display("Test %s timed out waiting for busy to clear", name);
        end
    endtask

    task automatic run_op(input string name, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b, input logic is_signed, input logic is_div);
        muldiv_pkg::muldiv_rsp_t exp;
        muldiv_pkg::word_t       ctrl;
        muldiv_pkg::word_t       exp_status;
        muldiv_pkg::word_t       rd;
        logic                    err;
        exp                              = expected_result(a, b, is_signed, is_div);
        ctrl                             = '0;
        ctrl[`MULDIV_CTRL_SIGNED]        = is_signed;
        ctrl[`MULDIV_CTRL_DIV]           = is_div;
        exp_status                       = '0;
        exp_status[`MULDIV_STATUS_DONE]  = 1'b1;
        exp_status[`MULDIV_STATUS_DBZ]   = is_div && (b == '0);
        apb_write(`MULDIV_ADDR_SRC_A, a, err);
        apb_write(`MULDIV_ADDR_SRC_B, b, err);
        apb_write(`MULDIV_ADDR_CTRL, ctrl, err);
        check_word({name, " pslverr"}, 32'd0, {31'd0, err});
        wait_idle(name);
        apb_read(`MULDIV_ADDR_HI, rd);
        check_word({name, " hi"}, exp.hi, rd);
        apb_read(`MULDIV_ADDR_LO, rd);
        check_word({name, " lo"}, exp.lo, rd);
        apb_read(`MULDIV_ADDR_STATUS, rd);
        check_word({name, " status"}, exp_status, rd);
    endtask

    // Second command while a divide runs must bounce and leave the divide intact
    task automatic busy_refusal(input muldiv_pkg::word_t a, input muldiv_pkg::word_t b);
        muldiv_pkg::muldiv_rsp_t exp;
        muldiv_pkg::word_t       rd;
        logic                    err;
        exp = expected_result(a, b, 1'b1, 1'b0 | 1'b1);
        apb_write(`MULDIV_ADDR_SRC_A, a, err);
        apb_write(`MULDIV_ADDR_SRC_B, b, err);
        apb_write(`MULDIV_ADDR_CTRL, 32'h3, err);
        apb_write(`MULDIV_ADDR_SRC_A, ~a, err);            // Operands are frozen by now
        apb_write(`MULDIV_ADDR_CTRL, 32'h1, err);
        check_word("refuse pslverr", 32'd1, {31'd0, err});
        apb_read(`MULDIV_ADDR_STATUS, rd);
        check_word("refuse busy", 32'd1, {31'd0, rd[`MULDIV_STATUS_BUSY]});
        wait_idle("refuse");
        apb_read(`MULDIV_ADDR_HI, rd);
        check_word("refuse hi", exp.hi, rd);
        apb_read(`MULDIV_ADDR_LO, rd);
        check_word("refuse lo", exp.lo, rd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        muldiv_pkg::word_t a;
        muldiv_pkg::word_t b;
        muldiv_pkg::word_t rd;
        muldiv_pkg::word_t edges [3];
        logic              err;
        clk           = 1'b0;
        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        value_errors  = 0;
        timeouts      = 0;
        timing_errors = 0;
        lcg_state     = 32'h86c1_653e;
        edges         = '{32'h0, 32'h1, 32'hffff_ffff};
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(`MULDIV_ADDR_HI, rd);
        check_word("reset hi", 32'd0, rd);
        apb_read(`MULDIV_ADDR_LO, rd);
        check_word("reset lo", 32'd0, rd);
        apb_read(`MULDIV_ADDR_STATUS, rd);
        check_word("reset status", 32'd0, rd);

        a = next_rand();
        b = next_rand();
        apb_write(`MULDIV_ADDR_SRC_A, a, err);
        apb_write(`MULDIV_ADDR_SRC_B, b, err);
        apb_read(`MULDIV_ADDR_SRC_A, rd);
        check_word("readback src_a", a, rd);
        apb_read(`MULDIV_ADDR_SRC_B, rd);
        check_word("readback src_b", b, rd);

        foreach (edges[i]) begin
            foreach (edges[j]) begin
                run_op($sformatf("umul_edge_%0d_%0d", i, j), edges[i], edges[j], 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            run_op($sformatf("umul_rand_%0d", i), next_rand(), next_rand(), 1'b0, 1'b0);
        end

        run_op("smul_pos_pos", 32'd3, 32'd1234567, 1'b1, 1'b0);       // Small multiplier ends early
        run_op("smul_neg_pos", -32'sd3, 32'd1234567, 1'b1, 1'b0);
        run_op("smul_pos_neg", 32'd200, -32'sd99999, 1'b1, 1'b0);
        run_op("smul_neg_neg", -32'sd70000, -32'sd5, 1'b1, 1'b0);
        run_op("smul_min_min", 32'h8000_0000, 32'h8000_0000, 1'b1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            run_op($sformatf("smul_rand_%0d", i), next_rand(), next_rand(), 1'b1, 1'b0);
        end

        for (int i = 0; i < 8; i++) begin
            a = next_rand();
            b = next_rand() >> (i * 3);                                // Spread of divisor sizes
            if (b == '0) begin
                b = 32'd7;
            end
            run_op($sformatf("udiv_rand_%0d", i), a, b, 1'b0, 1'b1);
            run_op($sformatf("sdiv_rand_%0d", i), a, b, 1'b1, 1'b1);
        end
        run_op("sdiv_min_neg1", 32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1);
        run_op("udiv_min_ones", 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1);

        run_op("udiv_zero", 32'hdead_beef, 32'd0, 1'b0, 1'b1);
        run_op("sdiv_zero", -32'sd12345, 32'd0, 1'b1, 1'b1);

        busy_refusal(-32'sd1000001, 32'd37);

        repeat (5) @(posedge clk);
        $display("Errors: value %0d, timeout %0d, timing %0d",
                 value_errors, timeouts, timing_errors);
        if (value_errors == 0 && timeouts == 0 && timing_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
